// ==== hdl/link_pkg.sv ====
/*
 * Game link shared definitions: UART timing, message tags,
 * card slot geometry, card codes and the message byte layout
 */
package link_pkg;

    localparam int CLKS_PER_BIT = 16;  // Short bit time for simulation
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_CNT_W-1:0] HALF_BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // Receiver FSM encodings
    localparam logic [1:0] RX_IDLE = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA = 2'd2;
    localparam logic [1:0] RX_STOP = 2'd3;

    localparam int NUM_SLOTS = 9;
    localparam int SLOT_W = 4;
    localparam int CARD_W = 4;
    localparam int TAG_W = 4;

    localparam logic [TAG_W-1:0] TAG_CTRL = TAG_W'(0);
    localparam logic [TAG_W-1:0] TAG_FIRST_CARD = TAG_W'(1);
    localparam logic [TAG_W-1:0] TAG_LAST_CARD = TAG_W'(9);

    localparam int HAND_W = 7;  // Worst case nine tens is 90
    localparam logic [HAND_W-1:0] BLACKJACK = HAND_W'(21);
    localparam logic [HAND_W-1:0] FACE_SCORE = HAND_W'(10);
    localparam logic [HAND_W-1:0] ACE_BONUS = HAND_W'(10);

    localparam logic [CARD_W-1:0] CARD_EMPTY = CARD_W'(0);
    localparam logic [CARD_W-1:0] CARD_ACE = CARD_W'(1);
    localparam logic [CARD_W-1:0] CARD_TEN = CARD_W'(10);
    localparam logic [CARD_W-1:0] CARD_KING = CARD_W'(13);  // 14 and 15 are invalid

    typedef struct packed {
        logic spare;
        logic start;
        logic deal;
        logic dealer_finished;
        logic [TAG_W-1:0] tag;
    } ctrl_msg_t;

    typedef struct packed {
        logic [CARD_W-1:0] value;
        logic [TAG_W-1:0] tag;
    } card_msg_t;

    typedef union packed {
        logic [7:0] raw;
        ctrl_msg_t ctrl;
        card_msg_t card;
    } msg_byte_t;

endpackage

// ==== hdl/card_if.sv ====
/*
 * Card slot bus: single-slot write port plus the full slot contents
 */
`timescale 1ns/1ps

interface card_if
    import link_pkg::*;
();

    logic wr_en;
    logic [SLOT_W-1:0] wr_slot;
    logic [CARD_W-1:0] wr_value;
    logic [NUM_SLOTS-1:0][CARD_W-1:0] cards;  // Slot 0 in low nibble

    modport writer (output wr_en, output wr_slot, output wr_value);

    modport tbl (input wr_en, input wr_slot, input wr_value, output cards);

    modport reader (input cards);

endinterface

// ==== hdl/uart_rx.sv ====
/*
 * UART receiver, 8N1 with midpoint sampling
 * Gives a one-cycle byte strobe and a sticky frame error
 */
`timescale 1ns/1ps

module uart_rx import link_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       frame_error
);

    logic rx_meta;
    logic rx_sync;
    logic [1:0] state;
    logic [BIT_CNT_W-1:0] tick_cnt;
    logic [2:0] bit_idx;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx <= '0;
            byte_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_sync) begin
                        state <= RX_IDLE;  // Glitch, not a start bit
                    end else if (tick_cnt == HALF_BIT_LAST) begin
                        tick_cnt <= '0;
                        bit_idx <= '0;
                        state <= RX_DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick_cnt == BIT_LAST) begin
                        tick_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin  // RX_STOP
                    if (tick_cnt == BIT_LAST) begin
                        state <= RX_IDLE;
                        if (rx_sync) begin
                            byte_valid <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;  // Held until reset
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data shifter, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && tick_cnt == BIT_LAST) begin
            byte_data <= {rx_sync, byte_data[7:1]};
        end
    end

    a_single_strobe: assert property (
        @(posedge clk) disable iff (rst) byte_valid |=> !byte_valid
    );

endmodule

// ==== hdl/msg_decoder.sv ====
/*
 * Message decoder: low nibble tag selects control flags or a card slot write
 */
`timescale 1ns/1ps

module msg_decoder import link_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      byte_valid,
    input  msg_byte_t byte_data,
    output logic      start,
    output logic      deal,
    output logic      dealer_finished,
    card_if.writer    cw
);

    logic is_ctrl;
    logic is_card;

    assign is_ctrl = (byte_data.ctrl.tag == TAG_CTRL);
    assign is_card = (byte_data.card.tag >= TAG_FIRST_CARD) &&
                     (byte_data.card.tag <= TAG_LAST_CARD);  // Tags 10..15 dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
            deal <= 1'b0;
            dealer_finished <= 1'b0;
            cw.wr_en <= 1'b0;
        end else begin
            cw.wr_en <= 1'b0;
            if (byte_valid) begin
                if (is_ctrl) begin
                    start <= byte_data.ctrl.start;
                    deal <= byte_data.ctrl.deal;
                    dealer_finished <= byte_data.ctrl.dealer_finished;
                end else if (is_card) begin
                    cw.wr_en <= 1'b1;
                end
            end
        end
    end

    // Write payload, qualified by wr_en downstream
    always_ff @(posedge clk) begin
        if (byte_valid && is_card) begin
            cw.wr_slot <= SLOT_W'(byte_data.card.tag - TAG_FIRST_CARD);
            cw.wr_value <= byte_data.card.value;
        end
    end

    a_slot_in_range: assert property (
        @(posedge clk) disable iff (rst) cw.wr_en |-> (cw.wr_slot < SLOT_W'(NUM_SLOTS))
    );

endmodule

// ==== hdl/card_table.sv ====
/*
 * Card table: nine card code registers written one slot at a time
 */
`timescale 1ns/1ps

module card_table import link_pkg::*; (
    input logic clk,
    input logic rst,
    card_if.tbl ct
);

    logic [NUM_SLOTS-1:0][CARD_W-1:0] slot_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_q <= '0;  // All slots empty
        end else if (ct.wr_en) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (ct.wr_slot == SLOT_W'(i)) begin
                    slot_q[i] <= ct.wr_value;
                end
            end
        end
    end

    assign ct.cards = slot_q;

    // Decoder must hand over a defined card code
    a_value_known: assert property (
        @(posedge clk) disable iff (rst) ct.wr_en |-> !$isunknown(ct.wr_value)
    );

endmodule

// ==== hdl/hand_scorer.sv ====
/*
 * Hand scorer: blackjack total with soft ace and bust flag, registered
 */
`timescale 1ns/1ps

module hand_scorer import link_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    card_if.reader            cr,
    output logic [HAND_W-1:0] hand_total,
    output logic              bust
);

    logic [HAND_W-1:0] hard_sum;
    logic [HAND_W-1:0] soft_sum;
    logic [HAND_W-1:0] total_d;
    logic has_ace;

    function automatic logic [HAND_W-1:0] card_score(input logic [CARD_W-1:0] code);
        logic [HAND_W-1:0] score;
        if (code == CARD_EMPTY) begin
            score = '0;
        end else if (code <= CARD_TEN) begin
            score = HAND_W'(code);  // Ace counts 1 here
        end else if (code <= CARD_KING) begin
            score = FACE_SCORE;
        end else begin
            score = '0;  // Invalid code
        end
        return score;
    endfunction

    always_comb begin
        hard_sum = '0;
        has_ace = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            hard_sum = hard_sum + card_score(cr.cards[i]);
            if (cr.cards[i] == CARD_ACE) begin
                has_ace = 1'b1;
            end
        end
    end

    // At most one ace can go soft without busting
    assign soft_sum = hard_sum + ACE_BONUS;
    assign total_d = (has_ace && soft_sum <= BLACKJACK) ? soft_sum : hard_sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            hand_total <= '0;
            bust <= 1'b0;
        end else begin
            hand_total <= total_d;
            bust <= (hard_sum > BLACKJACK);  // Soft total never busts
        end
    end

    a_bust_matches: assert property (
        @(posedge clk) disable iff (rst) bust == (hand_total > BLACKJACK)
    );

endmodule

// ==== hdl/game_link_rx.sv ====
/*
 * Game link receive path: UART, message decoder, card table and hand scorer
 */
`timescale 1ns/1ps

module game_link_rx import link_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rx,
    output logic                        start,
    output logic                        deal,
    output logic                        dealer_finished,
    output logic [NUM_SLOTS*CARD_W-1:0] cards,
    output logic [HAND_W-1:0]           hand_total,
    output logic                        bust,
    output logic                        frame_error
);

    logic byte_valid;
    logic [7:0] byte_data;

    card_if cif ();

    uart_rx u_uart_rx (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .frame_error (frame_error)
    );

    msg_decoder u_msg_decoder (
        .clk             (clk),
        .rst             (rst),
        .byte_valid      (byte_valid),
        .byte_data       (byte_data),
        .start           (start),
        .deal            (deal),
        .dealer_finished (dealer_finished),
        .cw              (cif.writer)
    );

    card_table u_card_table (
        .clk (clk),
        .rst (rst),
        .ct  (cif.tbl)
    );

    hand_scorer u_hand_scorer (
        .clk        (clk),
        .rst        (rst),
        .cr         (cif.reader),
        .hand_total (hand_total),
        .bust       (bust)
    );

    assign cards = cif.cards;  // Slot 0 in bits 3:0

endmodule

// ==== sim/game_link_rx_tb.sv ====
/*
 * Testbench for the game link receive path: drives UART frames on rx and
 * checks flags, card slots, score and frame error against a reference model
 */
`timescale 1ns/1ps

module game_link_rx_tb import link_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_HANDS = 8;
    localparam int NUM_RANDOM = 200;
    // Control, card writes, hands, ignored tags, framing, random traffic
    localparam int NUM_FRAMES = 8 + 11 + NUM_HANDS * NUM_SLOTS + 6 + 3 + NUM_RANDOM;
    localparam longint WATCHDOG_NS = 2 * NUM_FRAMES * 10 * CLKS_PER_BIT * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    logic rx;
    logic start;
    logic deal;
    logic dealer_finished;
    logic [NUM_SLOTS*CARD_W-1:0] cards;
    logic [HAND_W-1:0] hand_total;
    logic bust;
    logic frame_error;

    // Reference model of the table state
    logic exp_start;
    logic exp_deal;
    logic exp_fin;
    logic exp_ferr;
    logic [NUM_SLOTS-1:0][CARD_W-1:0] exp_cards;
    logic [HAND_W:0] exp_score;  // Bust flag above the total

    event check_ev;
    int error_count = 0;
    integer seed;

    logic [NUM_SLOTS*CARD_W-1:0] hands [NUM_HANDS] = '{
        36'h000000091,  // Ace as 11
        36'h000000911,  // Two aces, one soft, exactly 21
        36'h0000005CD,  // Face cards, bust
        36'h000000FE7,  // Invalid codes
        36'h00000065A,  // Hard 21
        36'h000000BAA,  // Bust
        36'h000000CD1,  // Ace forced hard
        36'h999999999
    };

    game_link_rx u_game_link_rx (
        .clk             (clk),
        .rst             (rst),
        .rx              (rx),
        .start           (start),
        .deal            (deal),
        .dealer_finished (dealer_finished),
        .cards           (cards),
        .hand_total      (hand_total),
        .bust            (bust),
        .frame_error     (frame_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [HAND_W:0] score_hand(input logic [NUM_SLOTS*CARD_W-1:0] hand);
        int sum;
        logic ace;
        logic [CARD_W-1:0] code;
        sum = 0;
        ace = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            code = hand[i*CARD_W +: CARD_W];
            if (code == 4'd1) begin
                ace = 1'b1;
                sum = sum + 1;
            end else if (code >= 4'd2 && code <= 4'd10) begin
                sum = sum + int'(code);
            end else if (code >= 4'd11 && code <= 4'd13) begin
                sum = sum + 10;  // Jack, queen, king
            end
        end
        if (ace && sum + 10 <= int'(BLACKJACK)) begin
            sum = sum + 10;
        end
        return {(sum > int'(BLACKJACK)), HAND_W'(sum)};
    endfunction

    function automatic msg_byte_t ctrl_byte(input logic s, input logic d, input logic f);
        msg_byte_t m;
        m.raw = '0;
        m.ctrl.start = s;
        m.ctrl.deal = d;
        m.ctrl.dealer_finished = f;
        m.ctrl.tag = 4'd0;
        return m;
    endfunction

    function automatic msg_byte_t card_byte(input int slot, input logic [CARD_W-1:0] value);
        msg_byte_t m;
        m.card.value = value;
        m.card.tag = 4'(slot + 1);
        return m;
    endfunction

    task automatic apply_msg(input msg_byte_t m);
        int slot;
        if (m.ctrl.tag == 4'd0) begin
            exp_start = m.ctrl.start;
            exp_deal = m.ctrl.deal;
            exp_fin = m.ctrl.dealer_finished;
        end else if (m.card.tag <= 4'd9) begin
            slot = int'(m.card.tag) - 1;
            exp_cards[slot] = m.card.value;
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        logic [9:0] bits;
        bits = {stop_level, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
    endtask

    task automatic send_and_check(input msg_byte_t m, input logic stop_level);
        send_frame(m.raw, stop_level);
        if (stop_level) begin
            apply_msg(m);
        end else begin
            exp_ferr = 1'b1;  // Bad frame leaves the table alone
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        @(negedge clk);
        -> check_ev;
    endtask

    task automatic report_mismatch(input string name, input logic [35:0] got,
                                   input logic [35:0] exp);
        error_count++;
        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Test FAILED");
        $fatal(1, "Stopping at first mismatch");
    endtask

    // Compares every output with the model
    always begin
        @(check_ev);
        exp_score = score_hand(exp_cards);
        assert (start == exp_start)
            else report_mismatch("start", 36'(start), 36'(exp_start));
        assert (deal == exp_deal)
            else report_mismatch("deal", 36'(deal), 36'(exp_deal));
        assert (dealer_finished == exp_fin)
            else report_mismatch("dealer_finished", 36'(dealer_finished), 36'(exp_fin));
        assert (cards == exp_cards)
            else report_mismatch("cards", cards, exp_cards);
        assert (hand_total == exp_score[HAND_W-1:0])
            else report_mismatch("hand_total", 36'(hand_total), 36'(exp_score[HAND_W-1:0]));
        assert (bust == exp_score[HAND_W])
            else report_mismatch("bust", 36'(bust), 36'(exp_score[HAND_W]));
        assert (frame_error == exp_ferr)
            else report_mismatch("frame_error", 36'(frame_error), 36'(exp_ferr));
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        seed = 32'h9711;
        rst <= 1'b1;
        rx <= 1'b1;
        exp_start = 1'b0;
        exp_deal = 1'b0;
        exp_fin = 1'b0;
        exp_ferr = 1'b0;
        exp_cards = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        -> check_ev;  // Reset values

        for (int i = 0; i < 8; i++) begin
            send_and_check(ctrl_byte(i[2], i[1], i[0]), 1'b1);
        end

        for (int s = 0; s < NUM_SLOTS; s++) begin
            send_and_check(card_byte(s, 4'(s + 2)), 1'b1);
        end
        send_and_check(card_byte(3, 4'd13), 1'b1);  // Rewrite keeps others
        send_and_check(card_byte(8, 4'd1), 1'b1);

        for (int h = 0; h < NUM_HANDS; h++) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                send_and_check(card_byte(s, hands[h][s*CARD_W +: CARD_W]), 1'b1);
            end
        end

        for (int t = 10; t < 16; t++) begin
            send_and_check(msg_byte_t'({4'(t + 3), 4'(t)}), 1'b1);
        end

        send_and_check(card_byte(2, 4'd7), 1'b0);
        send_and_check(ctrl_byte(1'b0, 1'b1, 1'b0), 1'b1);
        send_and_check(card_byte(2, 4'd7), 1'b1);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_and_check(msg_byte_t'(8'($random(seed))), 1'b1);
        end

        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== game_link_rx.f ====
hdl/link_pkg.sv
hdl/card_if.sv
hdl/uart_rx.sv
hdl/msg_decoder.sv
hdl/card_table.sv
hdl/hand_scorer.sv
hdl/game_link_rx.sv
sim/game_link_rx_tb.sv

// ==== Makefile ====
# Verilator build for the game link receive path and its testbench

VERILATOR ?= verilator
TOP       ?= game_link_rx_tb
FILELIST  ?= game_link_rx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
